// File: Makefile
# Verilator build and run for the always-on power and interrupt core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module mcu_ao_tb -f mcu_ao.f -Mdir obj_dir
	@out="$$(./obj_dir/Vmcu_ao_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: dv/mcu_ao_checker.sv
// assertion checker for the always-on power core
// pad sequencing order, reset levels and interrupt vector layout
`default_nettype none

module mcu_ao_checker
  import mcu_ao_pkg::*;
(
  input wire logic                 clk_i,
  input wire logic                 arst_n_i,
  input wire logic [N_TIMER-1:0]   rv_timer_intr_i,
  input wire logic                 irq_software_i,
  input wire logic                 irq_external_i,
  input wire logic                 dma_done_intr_i,
  input wire logic                 spi_intr_i,
  input wire logic                 spi_flash_intr_i,
  input wire logic [N_GPIO_AO-1:0] gpio_ao_intr_i,
  input wire logic [INTR_W-1:0]    intr_o,
  input wire logic                 cpu_switch_no,
  input wire logic                 cpu_iso_no,
  input wire logic                 cpu_rst_no,
  input wire logic                 periph_switch_no,
  input wire logic                 periph_iso_no,
  input wire logic                 periph_rst_no,
  input wire logic                 periph_clkgate_en_no,
  input wire logic [NUM_BANKS-1:0] bank_switch_no,
  input wire logic [NUM_BANKS-1:0] bank_iso_no,
  input wire logic [NUM_BANKS-1:0] bank_retentive_no,
  input wire logic [NUM_BANKS-1:0] bank_clkgate_en_no
);

  logic              armed = 1'b0;
  int                fail_cnt = 0;
  logic [INTR_W-1:0] layout_now;

  // pads are unknown until the first clock under reset
  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      armed <= 1'b1;
    end
  end

  // vector the sources map to with the fast group from low to high
  always_comb begin
    layout_now                                  = '0;
    layout_now[INTR_SW_BIT]                     = irq_software_i;
    layout_now[INTR_TIMER_BIT]                  = rv_timer_intr_i[0];
    layout_now[INTR_EXT_BIT]                    = irq_external_i;
    layout_now[INTR_FAST_LSB +: N_TIMER-1]      = rv_timer_intr_i[N_TIMER-1:1];
    layout_now[INTR_FAST_LSB + 3]               = dma_done_intr_i;
    layout_now[INTR_FAST_LSB + 4]               = spi_intr_i;
    layout_now[INTR_FAST_LSB + 5]               = spi_flash_intr_i;
    layout_now[INTR_FAST_LSB + 6 +: N_GPIO_AO]  = gpio_ao_intr_i;
  end

  // switch opens only with the domain held in reset and isolated
  a_cpu_switch: assert property (@(posedge clk_i) disable iff (!armed)
    !cpu_switch_no |-> !cpu_rst_no && !cpu_iso_no)
    else begin
      $error("cpu switch off too early");
      fail_cnt++;
    end
  a_periph_switch: assert property (@(posedge clk_i) disable iff (!armed)
    !periph_switch_no |-> !periph_rst_no && !periph_iso_no)
    else begin
      $error("peripheral switch off too early");
      fail_cnt++;
    end
  a_bank_switch: assert property (@(posedge clk_i) disable iff (!armed)
    (~bank_switch_no & bank_iso_no) == '0)
    else begin
      $error("bank switch off without isolation");
      fail_cnt++;
    end

  // isolation only behind a gated clock
  a_periph_iso: assert property (@(posedge clk_i) disable iff (!armed)
    !periph_iso_no |-> !periph_clkgate_en_no)
    else begin
      $error("peripheral isolated while clocked");
      fail_cnt++;
    end
  a_bank_iso: assert property (@(posedge clk_i) disable iff (!armed)
    (~bank_iso_no & bank_clkgate_en_no) == '0)
    else begin
      $error("bank isolated while clocked");
      fail_cnt++;
    end

  a_bank_ret: assert property (@(posedge clk_i) disable iff (!armed)
    (~bank_retentive_no & ~bank_switch_no) == '0)
    else begin
      $error("retention with switch off");
      fail_cnt++;
    end

  a_reset_idle: assert property (@(posedge clk_i) disable iff (!armed)
    !arst_n_i |-> &{cpu_switch_no, cpu_iso_no, cpu_rst_no, periph_switch_no, periph_iso_no,
                    periph_rst_no, periph_clkgate_en_no, bank_switch_no, bank_iso_no,
                    bank_retentive_no, bank_clkgate_en_no} && intr_o == '0)
    else begin
      $error("controls not idle in reset");
      fail_cnt++;
    end

  a_intr_layout: assert property (@(posedge clk_i) disable iff (!arst_n_i || !armed)
    intr_o == $past(layout_now))
    else begin
      $error("interrupt vector does not follow the sources");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: dv/mcu_ao_tb.sv
// testbench for the always-on power and interrupt core
// switch acknowledge model with random delays, directed and random power tests
`default_nettype none

module mcu_ao_tb;
  import mcu_ao_pkg::*;

  localparam int CLK_HALF   = 50;
  localparam int MAX_CYCLES = 2000;
  localparam int WAIT_LIMIT = 60;
  localparam int N_SOURCES  = 17;

  // selectors into the watch vector
  localparam int P_SW  = 0;
  localparam int P_ISO = 1;
  localparam int P_RST = 2;
  localparam int P_CLK = 3;
  localparam int C_SW  = 4;
  localparam int C_ISO = 5;
  localparam int C_RST = 6;
  localparam int P_ACK = 7;

  logic                   clk_i;
  logic                   arst_n_i;
  logic                   core_sleep_i;
  logic                   periph_off_i;
  logic [NUM_BANKS-1:0]   bank_off_i;
  logic [NUM_BANKS-1:0]   bank_retentive_i;
  // software, external, timer 0 to 3, dma, spi, spi flash, gpio 0 to 7
  logic [N_SOURCES-1:0]   src;
  logic [NUM_DOMAINS-1:0] ack_n;
  logic [INTR_W-1:0]      intr_o;
  logic                   cpu_switch_no;
  logic                   cpu_iso_no;
  logic                   cpu_rst_no;
  logic                   periph_switch_no;
  logic                   periph_iso_no;
  logic                   periph_rst_no;
  logic                   periph_clkgate_en_no;
  logic [NUM_BANKS-1:0]   bank_switch_no;
  logic [NUM_BANKS-1:0]   bank_iso_no;
  logic [NUM_BANKS-1:0]   bank_retentive_no;
  logic [NUM_BANKS-1:0]   bank_clkgate_en_no;
  logic [NUM_DOMAINS-1:0] sw_n;
  logic [7:0]             watch;
  int                     ack_wait [NUM_DOMAINS];
  bit                     freeze_ack;
  int                     cycles;
  int                     errors;
  int                     errors_at_start;
  int                     tests_run;
  int                     tests_failed;

  mcu_ao_top dut0 (
    .*,
    .irq_software_i       (src[0]),
    .irq_external_i       (src[1]),
    .rv_timer_intr_i      (src[5:2]),
    .dma_done_intr_i      (src[6]),
    .spi_intr_i           (src[7]),
    .spi_flash_intr_i     (src[8]),
    .gpio_ao_intr_i       (src[16:9]),
    .cpu_switch_ack_ni    (ack_n[DOM_CPU]),
    .periph_switch_ack_ni (ack_n[DOM_PERIPH]),
    .bank_switch_ack_ni   (ack_n[DOM_BANK0 +: NUM_BANKS])
  );

  bind mcu_ao_top mcu_ao_checker u_checker (.*);

  assign sw_n  = {bank_switch_no, periph_switch_no, cpu_switch_no};
  assign watch = {ack_n[DOM_PERIPH], cpu_rst_no, cpu_iso_no, cpu_switch_no,
                  periph_clkgate_en_no, periph_rst_no, periph_iso_no, periph_switch_no};

  always #(CLK_HALF) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // the switch acknowledge follows switch_no after 1 to 8 cycles
  always @(posedge clk_i) begin
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      if (ack_n[d] == sw_n[d]) begin
        ack_wait[d] <= 0;
      end else if (!freeze_ack) begin
        if (ack_wait[d] > 1) begin
          ack_wait[d] <= ack_wait[d] - 1;
        end else if (ack_wait[d] == 1 || $urandom % 8 == 0) begin
          ack_n[d] <= sw_n[d];
        end else begin
          ack_wait[d] <= 1 + int'($urandom % 7);
        end
      end
    end
  end

  // vector position of source k
  function automatic int layout_bit(input int k);
    if (k == 0) return INTR_SW_BIT;
    if (k == 1) return INTR_EXT_BIT;
    if (k == 2) return INTR_TIMER_BIT;
    return INTR_FAST_LSB + k - 3;
  endfunction

  // failed checks here plus failed assertions in the bound checker
  function automatic int total_errors();
    return errors + dut0.u_checker.fail_cnt;
  endfunction

  task automatic check(input bit ok, input string msg);
    if (!ok) begin
      $display("CHECK FAILED at time %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (total_errors() != errors_at_start) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name,
             (total_errors() == errors_at_start) ? "passed" : "failed");
    errors_at_start = total_errors();
  endtask

  // always moves to the next falling edge before looking
  task automatic wait_for_pad(input int sel, input logic lvl, input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (watch[sel] !== lvl && n < WAIT_LIMIT);
    if (watch[sel] !== lvl) begin
      $display("timed out at time %0t waiting for %s", $time, what);
      errors++;
    end
  endtask

  initial begin
    logic [INTR_W-1:0]    exp_intr;
    logic [NUM_BANKS-1:0] bank_sel;
    logic [NUM_BANKS-1:0] ret_sel;
    logic [NUM_BANKS-1:0] exp_sw;
    logic [NUM_BANKS-1:0] exp_ret;
    int                   n;
    void'($urandom(40));
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    core_sleep_i     = 1'b0;
    periph_off_i     = 1'b0;
    bank_off_i       = '0;
    bank_retentive_i = '0;
    src              = '0;
    ack_n            = '1;
    freeze_ack       = 1'b0;
    cycles           = 0;
    errors           = 0;
    errors_at_start  = 0;
    tests_run        = 0;
    tests_failed     = 0;
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;

    @(negedge clk_i);
    check(&watch[6:0] && &{bank_switch_no, bank_iso_no, bank_retentive_no,
          bank_clkgate_en_no} && intr_o == '0, "controls not idle after reset");
    end_test("reset values");

    // one source at a time shows up one edge after it is sampled
    for (int k = 0; k < N_SOURCES; k++) begin
      @(posedge clk_i);
      src    <= '0;
      src[k] <= 1'b1;
      @(posedge clk_i);
      @(negedge clk_i);
      exp_intr                = '0;
      exp_intr[layout_bit(k)] = 1'b1;
      check(intr_o == exp_intr,
            $sformatf("source %0d gave %h, expected bit %0d", k, intr_o, layout_bit(k)));
    end
    @(posedge clk_i);
    src <= '0;
    end_test("interrupt layout");

    @(posedge clk_i);
    periph_off_i <= 1'b1;
    wait_for_pad(P_CLK, 1'b0, "peripheral clock gate");
    check(periph_iso_no, "peripheral isolation ahead of clock gate");
    wait_for_pad(P_ISO, 1'b0, "peripheral isolation");
    check(periph_rst_no, "peripheral reset ahead of isolation");
    wait_for_pad(P_RST, 1'b0, "peripheral reset");
    check(periph_switch_no, "peripheral switch off ahead of reset");
    wait_for_pad(P_SW, 1'b0, "peripheral switch off");
    wait_for_pad(P_ACK, 1'b0, "peripheral switch ack");
    @(posedge clk_i);
    periph_off_i <= 1'b0;
    wait_for_pad(P_SW, 1'b1, "peripheral switch on");
    check(!periph_rst_no, "peripheral reset released before the ack");
    wait_for_pad(P_RST, 1'b1, "peripheral reset release");
    check(!periph_iso_no, "peripheral isolation dropped ahead of reset");
    wait_for_pad(P_ISO, 1'b1, "peripheral isolation release");
    check(!periph_clkgate_en_no, "peripheral clock back ahead of isolation");
    wait_for_pad(P_CLK, 1'b1, "peripheral clock release");
    check(periph_rst_no && periph_iso_no && periph_clkgate_en_no, "peripheral not restored");
    end_test("peripheral power cycle");

    // ack withheld on the way back up
    @(posedge clk_i);
    periph_off_i <= 1'b1;
    wait_for_pad(P_ACK, 1'b0, "peripheral switch ack");
    freeze_ack = 1'b1;
    repeat (4) @(posedge clk_i);
    periph_off_i <= 1'b0;
    wait_for_pad(P_SW, 1'b1, "peripheral switch on");
    repeat (20) begin
      @(negedge clk_i);
      check(!periph_rst_no && periph_switch_no, "peripheral moved on without the ack");
    end
    freeze_ack = 1'b0;
    wait_for_pad(P_RST, 1'b1, "peripheral reset release");
    wait_for_pad(P_CLK, 1'b1, "peripheral clock release");
    end_test("ack back-pressure");

    @(posedge clk_i);
    core_sleep_i <= 1'b1;
    wait_for_pad(C_SW, 1'b0, "cpu switch off");
    @(posedge clk_i);
    src[2] <= 1'b1;
    wait_for_pad(C_RST, 1'b1, "cpu reset release");
    wait_for_pad(C_ISO, 1'b1, "cpu isolation release");
    check(cpu_switch_no && cpu_rst_no && cpu_iso_no, "cpu not restored by timer interrupt");
    @(posedge clk_i);
    core_sleep_i <= 1'b0;
    @(posedge clk_i);
    src <= '0;
    end_test("cpu sleep and wake");

    bank_sel = NUM_BANKS'($urandom);
    ret_sel  = NUM_BANKS'($urandom);
    // bank 0 always switches off and bank 1 always retains
    bank_sel[1:0] = 2'b11;
    ret_sel[1:0]  = 2'b10;
    exp_sw  = ~(bank_sel & ~ret_sel);
    exp_ret = ~(bank_sel & ret_sel);
    @(posedge clk_i);
    bank_off_i       <= bank_sel;
    bank_retentive_i <= ret_sel;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while ((bank_switch_no != exp_sw || bank_retentive_no != exp_ret) && n < WAIT_LIMIT);
    check(bank_switch_no == exp_sw && bank_retentive_no == exp_ret,
          $sformatf("banks %b retention %b gave switch_no %b retentive_no %b",
                    bank_sel, ret_sel, bank_switch_no, bank_retentive_no));
    check(bank_iso_no == ~bank_sel && bank_clkgate_en_no == ~bank_sel,
          "bank isolation or clock gate not on the selected banks");
    @(posedge clk_i);
    bank_off_i       <= '0;
    bank_retentive_i <= '0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!(&{bank_switch_no, bank_iso_no, bank_retentive_no, bank_clkgate_en_no})
               && n < WAIT_LIMIT);
    check(&{bank_switch_no, bank_iso_no, bank_retentive_no, bank_clkgate_en_no},
          "banks not restored");
    end_test("random bank power-down");

    $display("tests run %0d, tests failed %0d, checks failed %0d, assertions failed %0d",
             tests_run, tests_failed, errors, dut0.u_checker.fail_cnt);
    if (total_errors() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mcu_ao.f
verilog/mcu_ao_pkg.sv
verilog/pwr_ctrl_if.sv
verilog/pwr_ack_sync.sv
verilog/irq_vector.sv
verilog/pwr_sequencer.sv
verilog/pwr_pad_drive.sv
verilog/mcu_ao_top.sv
dv/mcu_ao_checker.sv
dv/mcu_ao_tb.sv

// File: verilog/irq_vector.sv
// interrupt vector register
// packs the interrupt sources into the 32-bit layout and flags any pending bit
`default_nettype none

module irq_vector
  import mcu_ao_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic [N_TIMER-1:0]   rv_timer_intr_i,
  input  wire logic                 irq_software_i,
  input  wire logic                 irq_external_i,
  input  wire logic                 dma_done_intr_i,
  input  wire logic                 spi_intr_i,
  input  wire logic                 spi_flash_intr_i,
  input  wire logic [N_GPIO_AO-1:0] gpio_ao_intr_i,
  output logic      [INTR_W-1:0]    intr_o,
  output logic                      irq_pending_o
);

  logic [FAST_INTR_W-1:0] fast_intr;
  logic [INTR_W-1:0]      intr_d;

  // top fast bit is unused
  assign fast_intr = {1'b0, gpio_ao_intr_i, spi_flash_intr_i, spi_intr_i,
                      dma_done_intr_i, rv_timer_intr_i[N_TIMER-1:1]};

  always_comb begin
    intr_d                                  = '0;
    intr_d[INTR_SW_BIT]                     = irq_software_i;
    intr_d[INTR_TIMER_BIT]                  = rv_timer_intr_i[0];
    intr_d[INTR_EXT_BIT]                    = irq_external_i;
    intr_d[INTR_FAST_LSB +: FAST_INTR_W]    = fast_intr;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      intr_o <= '0;
    end else begin
      intr_o <= intr_d;
    end
  end

  // wake condition for the cpu domain
  assign irq_pending_o = |intr_o;

endmodule

`default_nettype wire

// File: verilog/mcu_ao_pkg.sv
// always-on power and interrupt core package
// domain counts, domain indices, interrupt layout and power states
`default_nettype none

package mcu_ao_pkg;

  // power domains
  localparam int unsigned NUM_BANKS   = 4;
  localparam int unsigned NUM_DOMAINS = 2 + NUM_BANKS;

  // domain index 0 is the cpu, 1 the peripherals, banks follow
  localparam int unsigned DOM_CPU    = 0;
  localparam int unsigned DOM_PERIPH = 1;
  localparam int unsigned DOM_BANK0  = 2;

  // interrupt vector layout
  localparam int unsigned INTR_W         = 32;
  localparam int unsigned FAST_INTR_W    = 15;
  localparam int unsigned N_TIMER        = 4;
  localparam int unsigned N_GPIO_AO      = 8;
  localparam int unsigned INTR_SW_BIT    = 3;
  localparam int unsigned INTR_TIMER_BIT = 7;
  localparam int unsigned INTR_EXT_BIT   = 11;
  localparam int unsigned INTR_FAST_LSB  = 16;

  // power-down walks top to bottom, power-up runs back through the last three
  typedef enum logic [3:0] {
    PWR_ON,
    PWR_CLK_OFF,
    PWR_ISO_ON,
    PWR_RST_ON,
    PWR_SWITCH_OFF,
    PWR_OFF,
    PWR_RET,
    PWR_SWITCH_ON,
    PWR_RST_OFF,
    PWR_ISO_OFF
  } pwr_state_e;

endpackage

`default_nettype wire

// File: verilog/mcu_ao_top.sv
// always-on power and interrupt core
// power gating sequencer for cpu, peripheral and memory bank domains
`default_nettype none

module mcu_ao_top
  import mcu_ao_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic                 core_sleep_i,
  input  wire logic                 periph_off_i,
  input  wire logic [NUM_BANKS-1:0] bank_off_i,
  input  wire logic [NUM_BANKS-1:0] bank_retentive_i,
  input  wire logic [N_TIMER-1:0]   rv_timer_intr_i,
  input  wire logic                 irq_software_i,
  input  wire logic                 irq_external_i,
  input  wire logic                 dma_done_intr_i,
  input  wire logic                 spi_intr_i,
  input  wire logic                 spi_flash_intr_i,
  input  wire logic [N_GPIO_AO-1:0] gpio_ao_intr_i,
  input  wire logic                 cpu_switch_ack_ni,
  input  wire logic                 periph_switch_ack_ni,
  input  wire logic [NUM_BANKS-1:0] bank_switch_ack_ni,
  output logic      [INTR_W-1:0]    intr_o,
  output logic                      cpu_switch_no,
  output logic                      cpu_iso_no,
  output logic                      cpu_rst_no,
  output logic                      periph_switch_no,
  output logic                      periph_iso_no,
  output logic                      periph_rst_no,
  output logic                      periph_clkgate_en_no,
  output logic      [NUM_BANKS-1:0] bank_switch_no,
  output logic      [NUM_BANKS-1:0] bank_iso_no,
  output logic      [NUM_BANKS-1:0] bank_retentive_no,
  output logic      [NUM_BANKS-1:0] bank_clkgate_en_no
);

  logic irq_pending;

  pwr_ctrl_if pwr ();

  // ack vector follows the domain index order
  pwr_ack_sync u_ack_sync (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .switch_ack_ni ({bank_switch_ack_ni, periph_switch_ack_ni, cpu_switch_ack_ni}),
    .pwr           (pwr.sync)
  );

  irq_vector u_irq_vector (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .rv_timer_intr_i  (rv_timer_intr_i),
    .irq_software_i   (irq_software_i),
    .irq_external_i   (irq_external_i),
    .dma_done_intr_i  (dma_done_intr_i),
    .spi_intr_i       (spi_intr_i),
    .spi_flash_intr_i (spi_flash_intr_i),
    .gpio_ao_intr_i   (gpio_ao_intr_i),
    .intr_o           (intr_o),
    .irq_pending_o    (irq_pending)
  );

  pwr_sequencer u_sequencer (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .core_sleep_i     (core_sleep_i),
    .periph_off_i     (periph_off_i),
    .bank_off_i       (bank_off_i),
    .bank_retentive_i (bank_retentive_i),
    .irq_pending_i    (irq_pending),
    .pwr              (pwr.seq)
  );

  pwr_pad_drive u_pad_drive (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .pwr                  (pwr.drive),
    .cpu_switch_no        (cpu_switch_no),
    .cpu_iso_no           (cpu_iso_no),
    .cpu_rst_no           (cpu_rst_no),
    .periph_switch_no     (periph_switch_no),
    .periph_iso_no        (periph_iso_no),
    .periph_rst_no        (periph_rst_no),
    .periph_clkgate_en_no (periph_clkgate_en_no),
    .bank_switch_no       (bank_switch_no),
    .bank_iso_no          (bank_iso_no),
    .bank_retentive_no    (bank_retentive_no),
    .bank_clkgate_en_no   (bank_clkgate_en_no)
  );

endmodule

`default_nettype wire

// File: verilog/pwr_ack_sync.sv
// power switch acknowledge synchronizer
// two flops per domain, inverted into an active-high switch-off flag
`default_nettype none

module pwr_ack_sync
  import mcu_ao_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  input  wire logic [NUM_DOMAINS-1:0] switch_ack_ni,
  pwr_ctrl_if.sync                    pwr
);

  logic [NUM_DOMAINS-1:0] ack_meta_q;
  logic [NUM_DOMAINS-1:0] ack_sync_q;

  // acks arrive from the switch cells with no relation to clk_i
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // switches are on out of reset
      ack_meta_q <= '1;
      ack_sync_q <= '1;
    end else begin
      ack_meta_q <= switch_ack_ni;
      ack_sync_q <= ack_meta_q;
    end
  end

  // active-low ack becomes switch-off flag
  assign pwr.ack_off = ~ack_sync_q;

endmodule

`default_nettype wire

// File: verilog/pwr_ctrl_if.sv
// per-domain power control bundle
// active-high controls from the sequencer, synchronized switch acknowledges back
`default_nettype none

interface pwr_ctrl_if
  import mcu_ao_pkg::*;
();

  // high means clock gated, isolated, in reset, switched off, retentive
  logic [NUM_DOMAINS-1:0] clk_en;
  logic [NUM_DOMAINS-1:0] iso_en;
  logic [NUM_DOMAINS-1:0] rst_en;
  logic [NUM_DOMAINS-1:0] switch_off;
  logic [NUM_DOMAINS-1:0] ret_en;

  // high once the switch has reported off
  logic [NUM_DOMAINS-1:0] ack_off;

  modport seq(output clk_en, iso_en, rst_en, switch_off, ret_en, input ack_off);

  modport sync(output ack_off);

  modport drive(input clk_en, iso_en, rst_en, switch_off, ret_en);

endinterface

`default_nettype wire

// File: verilog/pwr_pad_drive.sv
// power pad driver
// registers the controls and drives them active low per domain group
`default_nettype none

module pwr_pad_drive
  import mcu_ao_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            arst_n_i,
  pwr_ctrl_if.drive            pwr,
  output logic                 cpu_switch_no,
  output logic                 cpu_iso_no,
  output logic                 cpu_rst_no,
  output logic                 periph_switch_no,
  output logic                 periph_iso_no,
  output logic                 periph_rst_no,
  output logic                 periph_clkgate_en_no,
  output logic [NUM_BANKS-1:0] bank_switch_no,
  output logic [NUM_BANKS-1:0] bank_iso_no,
  output logic [NUM_BANKS-1:0] bank_retentive_no,
  output logic [NUM_BANKS-1:0] bank_clkgate_en_no
);

  // flopped so the pads see no decode glitches
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cpu_switch_no        <= 1'b1;
      cpu_iso_no           <= 1'b1;
      cpu_rst_no           <= 1'b1;
      periph_switch_no     <= 1'b1;
      periph_iso_no        <= 1'b1;
      periph_rst_no        <= 1'b1;
      periph_clkgate_en_no <= 1'b1;
      bank_switch_no       <= '1;
      bank_iso_no          <= '1;
      bank_retentive_no    <= '1;
      bank_clkgate_en_no   <= '1;
    end else begin
      // cpu has no clock gate pad
      cpu_switch_no        <= ~pwr.switch_off[DOM_CPU];
      cpu_iso_no           <= ~pwr.iso_en[DOM_CPU];
      cpu_rst_no           <= ~pwr.rst_en[DOM_CPU];
      periph_switch_no     <= ~pwr.switch_off[DOM_PERIPH];
      periph_iso_no        <= ~pwr.iso_en[DOM_PERIPH];
      periph_rst_no        <= ~pwr.rst_en[DOM_PERIPH];
      periph_clkgate_en_no <= ~pwr.clk_en[DOM_PERIPH];
      // banks have no reset pad
      bank_switch_no       <= ~pwr.switch_off[DOM_BANK0 +: NUM_BANKS];
      bank_iso_no          <= ~pwr.iso_en[DOM_BANK0 +: NUM_BANKS];
      bank_retentive_no    <= ~pwr.ret_en[DOM_BANK0 +: NUM_BANKS];
      bank_clkgate_en_no   <= ~pwr.clk_en[DOM_BANK0 +: NUM_BANKS];
    end
  end

endmodule

`default_nettype wire

// File: verilog/pwr_sequencer.sv
// power sequencer
// one state machine per domain orders clock gate, isolation, reset and switch
`default_nettype none

module pwr_sequencer
  import mcu_ao_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic                 core_sleep_i,
  input  wire logic                 periph_off_i,
  input  wire logic [NUM_BANKS-1:0] bank_off_i,
  input  wire logic [NUM_BANKS-1:0] bank_retentive_i,
  input  wire logic                 irq_pending_i,
  pwr_ctrl_if.seq                   pwr
);

  logic [NUM_DOMAINS-1:0] off_req;
  logic [NUM_DOMAINS-1:0] ret_sel;
  pwr_state_e             state_q [NUM_DOMAINS];

  // request forming, retention only exists for banks
  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_req
    if (d == DOM_CPU) begin : g_cpu
      // cpu sleeps only while nothing is pending
      assign off_req[d] = core_sleep_i & ~irq_pending_i;
      assign ret_sel[d] = 1'b0;
    end else if (d == DOM_PERIPH) begin : g_periph
      assign off_req[d] = periph_off_i;
      assign ret_sel[d] = 1'b0;
    end else begin : g_bank
      assign off_req[d] = bank_off_i[d-DOM_BANK0];
      assign ret_sel[d] = bank_retentive_i[d-DOM_BANK0];
    end
  end

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_fsm
    pwr_state_e state_d;

    always_comb begin
      state_d = state_q[d];
      case (state_q[d])
        PWR_ON: begin
          if (off_req[d]) state_d = PWR_CLK_OFF;
        end
        PWR_CLK_OFF: state_d = PWR_ISO_ON;
        // banks in retention keep reset and switch untouched
        PWR_ISO_ON: state_d = ret_sel[d] ? PWR_RET : PWR_RST_ON;
        PWR_RST_ON: state_d = PWR_SWITCH_OFF;
        PWR_SWITCH_OFF: begin
          if (pwr.ack_off[d]) state_d = PWR_OFF;
        end
        PWR_OFF: begin
          if (!off_req[d]) state_d = PWR_SWITCH_ON;
        end
        PWR_RET: begin
          if (!off_req[d]) state_d = PWR_RST_OFF;
        end
        PWR_SWITCH_ON: begin
          if (!pwr.ack_off[d]) state_d = PWR_RST_OFF;
        end
        PWR_RST_OFF: state_d = PWR_ISO_OFF;
        PWR_ISO_OFF: state_d = PWR_ON;
        default: state_d = PWR_ON;
      endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        state_q[d] <= PWR_ON;
      end else begin
        state_q[d] <= state_d;
      end
    end
  end

  // control decode, each state adds or drops one control
  always_comb begin
    for (int i = 0; i < NUM_DOMAINS; i++) begin
      pwr.clk_en[i]     = (state_q[i] != PWR_ON);
      pwr.iso_en[i]     = !(state_q[i] inside {PWR_ON, PWR_CLK_OFF, PWR_ISO_OFF});
      pwr.rst_en[i]     = state_q[i] inside {PWR_RST_ON, PWR_SWITCH_OFF, PWR_OFF,
                                              PWR_SWITCH_ON};
      pwr.switch_off[i] = state_q[i] inside {PWR_SWITCH_OFF, PWR_OFF};
      pwr.ret_en[i]     = (state_q[i] == PWR_RET);
    end
  end

endmodule

`default_nettype wire
